// File: src/MonopixConfPkg.sv
package MonopixConfPkg;

    // Periphery geometry
    localparam int NumFlavors = 4;   // PMOS_NOSF, PMOS, COMP, HV
    localparam int NumCols    = 8;   // Columns per flavor

    // Global configuration word
    localparam int ConfBits = 12;

    // Field offsets, one bit per flavor in each field
    localparam int EnReadPos        = 0;
    localparam int EnTestPatternPos = 4;
    localparam int EnHitOrPos       = 8;

    typedef logic [ConfBits-1:0]   ConfWordT;
    typedef logic [NumFlavors-1:0] FlavorMaskT;

    // Power-up word, also forced by DefConf
    // All flavors read out and drive HitOr, no test pattern
    localparam ConfWordT ConfDefault = {
        FlavorMaskT'('1),   // EnHitOr
        FlavorMaskT'('0),   // EnTestPattern
        FlavorMaskT'('1)    // EnRead
    };

endpackage

// File: src/MonopixReadoutPkg.sv
package MonopixReadoutPkg;

    // Bunch crossing timestamp
    localparam int BcidBits = 6;
    typedef logic [BcidBits-1:0] BcidT;   // Gray coded

    // Hit address
    localparam int RowBits = 6;
    typedef logic [RowBits-1:0] RowT;
    typedef logic [2:0]         ColIdxT;

    // Serial frame, MSB first on the wire
    // {start bit, column, row, bcid}
    localparam int WordBits = 16;
    typedef logic [WordBits-1:0] HitWordT;

    // Fixed frame sent in test pattern mode
    localparam HitWordT TestPatternWord = 16'hA5C3;

    // Output serializer
    typedef enum logic {
        SerIdle,
        SerShift
    } SerStateT;

endpackage

// File: src/ConfReg.sv
`timescale 1ns/1ns

module ConfReg
    import MonopixConfPkg::*;
(
    input  logic     ClkBx,
    input  logic     reset_ff,
    input  logic     DefConf,     // Force the default word
    input  logic     ConfShift,   // Shift strobe
    input  logic     ConfLoad,    // Copy shift register to active word
    input  logic     ConfIn,
    output logic     ConfOut,
    output ConfWordT Conf
);

    ConfWordT shiftReg;
    ConfWordT activeReg;

    // Shift has priority, a load in the same cycle is lost
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            shiftReg  <= '0;
            activeReg <= ConfDefault;
        end else if (ConfShift) begin
            shiftReg <= {shiftReg[ConfBits-2:0], ConfIn};   // Toward MSB
        end else if (ConfLoad) begin
            activeReg <= shiftReg;
        end
    end

    // Serial readback of the shift chain
    assign ConfOut = shiftReg[ConfBits-1];

    // Override pin wins over whatever was loaded
    assign Conf = DefConf ? ConfDefault : activeReg;

endmodule

// File: src/BcidCounter.sv
`timescale 1ns/1ns

module BcidCounter
    import MonopixReadoutPkg::*;
(
    input  logic ClkBx,
    input  logic reset_ff,
    input  logic BcidReset,
    output BcidT Bcid
);

    logic [BcidBits-1:0] binCount;

    // Free running, wraps at 64
    always_ff @(posedge ClkBx) begin
        if (reset_ff || BcidReset) begin
            binCount <= '0;
        end else begin
            binCount <= binCount + 1'b1;
        end
    end

    // Gray code so only one bit toggles per crossing
    // on the wide distribution to the columns
    assign Bcid = binCount ^ (binCount >> 1);

endmodule

// File: src/ColumnBuffer.sv
`timescale 1ns/1ns

module ColumnBuffer
    import MonopixConfPkg::*;
    import MonopixReadoutPkg::*;
(
    input  logic               ClkBx,
    input  logic               reset_ff,
    input  logic               EnRead,
    input  logic               EnTestPattern,
    input  logic               EnHitOr,
    input  logic               Freeze,
    input  logic               Take,      // Serializer accepted Word
    input  logic [NumCols-1:0] ColHit,
    input  RowT  [NumCols-1:0] ColRow,
    input  BcidT               Bcid,
    output logic               WordValid,
    output logic               HitOr,
    output HitWordT            Word
);

    logic [NumCols-1:0] occupied;
    RowT                rowMem  [NumCols];
    BcidT               bcidMem [NumCols];

    ColIdxT selCol;
    logic   anyOcc;

    // Occupancy flags
    // Take needs WordValid, hence Freeze, so capture and clear never meet
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            occupied <= '0;
        end else begin
            for (int c = 0; c < NumCols; c++) begin
                if (EnRead && !Freeze && ColHit[c] && !occupied[c]) begin
                    occupied[c] <= 1'b1;
                end
            end
            if (Take && !EnTestPattern) begin
                occupied[selCol] <= 1'b0;   // Frame handed off
            end
        end
    end

    // Hit payload, written only when a column fills
    always_ff @(posedge ClkBx) begin
        for (int c = 0; c < NumCols; c++) begin
            if (EnRead && !Freeze && ColHit[c] && !occupied[c]) begin
                rowMem[c]  <= ColRow[c];
                bcidMem[c] <= Bcid;   // Timestamp before this edge
            end
        end
    end

    // Lowest occupied column wins
    always_comb begin
        selCol = '0;
        for (int c = NumCols - 1; c >= 0; c--) begin
            if (occupied[c]) begin
                selCol = ColIdxT'(c);
            end
        end
    end

    assign anyOcc = |occupied;

    // Readout only while frozen
    // Test pattern mode always has a word ready
    assign WordValid = EnTestPattern | (Freeze & anyOcc);

    always_comb begin
        if (EnTestPattern) begin
            Word = TestPatternWord;
        end else begin
            Word = {1'b1, selCol, rowMem[selCol], bcidMem[selCol]};
        end
    end

    // Fast trigger, straight from the discriminators
    assign HitOr = EnHitOr & (|ColHit);

endmodule

// File: src/HitSerializer.sv
`timescale 1ns/1ns

module HitSerializer
    import MonopixReadoutPkg::*;
(
    input  logic    ClkBx,
    input  logic    reset_ff,
    input  logic    Read,
    input  logic    WordValid,
    input  HitWordT Word,
    output logic    Take,
    output logic    TokenOut,
    output logic    DataOut
);

    SerStateT state;
    HitWordT  shiftReg;
    logic [3:0] bitCnt;   // Counts the 16 frame bits

    // Token only offered while idle
    assign TokenOut = WordValid && (state == SerIdle);

    // Read outside the token window is dropped here
    assign Take = TokenOut && Read;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            state  <= SerIdle;
            bitCnt <= '0;
        end else begin
            case (state)
                SerIdle: begin
                    if (Take) begin
                        state  <= SerShift;
                        bitCnt <= '0;
                    end
                end
                SerShift: begin
                    bitCnt <= bitCnt + 1'b1;
                    if (bitCnt == 4'd15) begin
                        state <= SerIdle;   // Last bit just went out
                    end
                end
                default: state <= SerIdle;
            endcase
        end
    end

    // Frame data
    always_ff @(posedge ClkBx) begin
        if (Take) begin
            shiftReg <= Word;
        end else if (state == SerShift) begin
            shiftReg <= shiftReg << 1;
        end
    end

    // MSB first, line held low between frames
    assign DataOut = (state == SerShift) & shiftReg[WordBits-1];

endmodule

// File: src/MonopixTop.sv
`timescale 1ns/1ns

module MonopixTop
    import MonopixConfPkg::*;
    import MonopixReadoutPkg::*;
(
    input  logic                                ClkBx,
    input  logic                                reset_ff,
    input  logic                                BcidReset,
    input  logic                                DefConf,
    input  logic                                ConfShift,
    input  logic                                ConfLoad,
    input  logic                                ConfIn,
    output logic                                ConfOut,
    input  logic [NumFlavors-1:0][NumCols-1:0]  ColHit,
    input  RowT  [NumFlavors-1:0][NumCols-1:0]  ColRow,
    input  FlavorMaskT                          Freeze,
    input  FlavorMaskT                          Read,
    output FlavorMaskT                          TokenOut,
    output FlavorMaskT                          DataOut,
    output FlavorMaskT                          HitOr
);

    ConfWordT conf;
    BcidT     bcid;

    ConfReg i_confReg (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .DefConf   (DefConf),
        .ConfShift (ConfShift),
        .ConfLoad  (ConfLoad),
        .ConfIn    (ConfIn),
        .ConfOut   (ConfOut),
        .Conf      (conf)
    );

    // One timestamp shared by all flavors
    BcidCounter i_bcidCounter (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .BcidReset (BcidReset),
        .Bcid      (bcid)
    );

    for (genvar f = 0; f < NumFlavors; f++) begin : gFlavor
        logic    wordValid;
        logic    take;
        HitWordT word;

        ColumnBuffer i_columnBuffer (
            .ClkBx         (ClkBx),
            .reset_ff      (reset_ff),
            .EnRead        (conf[EnReadPos + f]),
            .EnTestPattern (conf[EnTestPatternPos + f]),
            .EnHitOr       (conf[EnHitOrPos + f]),
            .Freeze        (Freeze[f]),
            .Take          (take),
            .ColHit        (ColHit[f]),
            .ColRow        (ColRow[f]),
            .Bcid          (bcid),
            .WordValid     (wordValid),
            .HitOr         (HitOr[f]),
            .Word          (word)
        );

        HitSerializer i_hitSerializer (
            .ClkBx     (ClkBx),
            .reset_ff  (reset_ff),
            .Read      (Read[f]),
            .WordValid (wordValid),
            .Word      (word),
            .Take      (take),
            .TokenOut  (TokenOut[f]),
            .DataOut   (DataOut[f])
        );
    end

endmodule

// File: verif/MonopixTb_asserts.sv
`timescale 1ns/1ns

module MonopixTb_asserts
    import MonopixConfPkg::*;
(
    input logic       ClkBx,
    input logic       reset_ff,
    input FlavorMaskT Take,
    input FlavorMaskT WordValid,
    input FlavorMaskT Shifting,        // Serializer in SerShift
    input FlavorMaskT TokenOut,
    input FlavorMaskT Freeze,
    input FlavorMaskT EnTestPattern
);

    for (genvar f = 0; f < NumFlavors; f++) begin : gCheck
        logic [4:0] shiftLen;   // Consecutive busy cycles

        always_ff @(posedge ClkBx) begin
            if (reset_ff || !Shifting[f]) begin
                shiftLen <= '0;
            end else begin
                shiftLen <= shiftLen + 5'd1;
            end
        end

        // Accepted word starts a frame on the next cycle
        assert property (@(posedge ClkBx) disable iff (reset_ff)
            Take[f] |=> Shifting[f] && $past(WordValid[f]))
            else $error("Take without WordValid or frame start on flavor %0d", f);

        // One frame is 16 bit times
        assert property (@(posedge ClkBx) disable iff (reset_ff)
            Shifting[f] |-> shiftLen < 5'd16)
            else $error("Serializer of flavor %0d busy too long", f);

        assert property (@(posedge ClkBx) disable iff (reset_ff)
            $fell(Shifting[f]) |-> shiftLen == 5'd16)
            else $error("Serializer of flavor %0d left SerShift after %0d cycles", f, shiftLen);

        // Frozen columns cannot gain a word
        assert property (@(posedge ClkBx) disable iff (reset_ff)
            $rose(TokenOut[f]) |-> (Freeze[f] || EnTestPattern[f])
                && ($rose(Freeze[f]) || $rose(EnTestPattern[f]) || $fell(Shifting[f])))
            else $error("TokenOut rose on flavor %0d without a new word offer", f);
    end

endmodule

bind MonopixTop MonopixTb_asserts i_asserts (
    .ClkBx         (ClkBx),
    .reset_ff      (reset_ff),
    .Take          ({gFlavor[3].take, gFlavor[2].take, gFlavor[1].take, gFlavor[0].take}),
    .WordValid     ({gFlavor[3].wordValid, gFlavor[2].wordValid,
                     gFlavor[1].wordValid, gFlavor[0].wordValid}),
    .Shifting      ({gFlavor[3].i_hitSerializer.state == SerShift,
                     gFlavor[2].i_hitSerializer.state == SerShift,
                     gFlavor[1].i_hitSerializer.state == SerShift,
                     gFlavor[0].i_hitSerializer.state == SerShift}),
    .TokenOut      (TokenOut),
    .Freeze        (Freeze),
    .EnTestPattern (conf[EnTestPatternPos +: NumFlavors])
);

// File: verif/MonopixTb.sv
`timescale 1ns/1ns

module MonopixTb
    import MonopixConfPkg::*;
    import MonopixReadoutPkg::*;
();

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 10;
    localparam int TokenWait   = 40;   // Cycles allowed for a token to show up

    // Rough length of each test in cycles
    localparam int SingleHitLen   = NumFlavors * 45;
    localparam int OrderLen       = 160;
    localparam int HitOrLen       = 30;
    localparam int ConfWriteLen   = 150;
    localparam int ReadbackLen    = 20 + SingleHitLen;
    localparam int BcidLen        = 120;
    localparam int WatchdogCycles = ResetCycles + SingleHitLen + OrderLen + HitOrLen
                                    + ConfWriteLen + ReadbackLen + BcidLen + 200;

    // {EnHitOr, EnTestPattern, EnRead}
    // Flavor 1 not read, flavor 2 without HitOr, flavor 3 in test pattern mode
    localparam logic [11:0] ConfTestWord = {4'b1011, 4'b1000, 4'b1101};
    localparam logic [15:0] PatternFrame = 16'hA5C3;

    logic ClkBx;
    logic reset_ff;
    logic bcidReset;
    logic defConf;
    logic confShift;
    logic confLoad;
    logic confIn;
    logic confOut;
    logic [NumFlavors-1:0][NumCols-1:0] colHit;
    RowT  [NumFlavors-1:0][NumCols-1:0] colRow;
    FlavorMaskT freeze;
    FlavorMaskT readReq;
    FlavorMaskT tokenOut;
    FlavorMaskT dataOut;
    FlavorMaskT hitOr;

    logic [5:0] bcidCnt;    // Binary timestamp model
    logic [5:0] bcidGray;
    int         errorCount;
    int         checkCount;

    MonopixTop i_dut (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .BcidReset (bcidReset),
        .DefConf   (defConf),
        .ConfShift (confShift),
        .ConfLoad  (confLoad),
        .ConfIn    (confIn),
        .ConfOut   (confOut),
        .ColHit    (colHit),
        .ColRow    (colRow),
        .Freeze    (freeze),
        .Read      (readReq),
        .TokenOut  (tokenOut),
        .DataOut   (dataOut),
        .HitOr     (hitOr)
    );

    initial begin
        ClkBx = 1'b0;
        forever #(ClkPeriod / 2) ClkBx = ~ClkBx;
    end

    function automatic logic [5:0] grayOf(input logic [5:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // Start bit, column, row, timestamp
    function automatic logic [15:0] frameOf(input int col, input logic [5:0] row,
                                            input logic [5:0] bcid);
        logic [2:0] colBits;
        colBits = col[2:0];
        return {1'b1, colBits, row, bcid};
    endfunction

    // Counter model, cleared on the same edges as the DUT
    always @(posedge ClkBx) begin
        if (reset_ff || bcidReset) begin
            bcidCnt <= '0;
        end else begin
            bcidCnt <= bcidCnt + 6'd1;
        end
    end

    assign bcidGray = grayOf(bcidCnt);

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic waitToken(input int f, output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < TokenWait) begin
            @(negedge ClkBx);
            seen = tokenOut[f];
            n++;
        end
        if (!seen) begin
            errorCount++;
            $display("Flavor %0d did not raise TokenOut within %0d cycles", f, TokenWait);
        end
    endtask

    // Answer the token with Read and collect the 16 frame bits
    task automatic readFrame(input int f, input logic [15:0] expected, input string what);
        bit          seen;
        logic [15:0] got;
        waitToken(f, seen);
        if (seen) begin
            @(posedge ClkBx);
            readReq[f] <= 1'b1;
            @(posedge ClkBx);
            readReq[f] <= 1'b0;   // Frame loads at this edge
            for (int i = WordBits - 1; i >= 0; i--) begin
                @(negedge ClkBx);
                got[i] = dataOut[f];
            end
            checkEqual(got, expected, what);
            @(negedge ClkBx);
            checkEqual(dataOut[f], 1'b0, $sformatf("DataOut idle flavor %0d", f));
        end
    endtask

    // One-cycle hit, returns the timestamp ahead of the capture edge
    task automatic placeHit(input int f, input int c, input logic [5:0] row,
                            output logic [5:0] expBcid);
        @(posedge ClkBx);
        colRow[f][c] <= row;
        colHit[f][c] <= 1'b1;
        @(negedge ClkBx);
        expBcid = bcidGray;
        @(posedge ClkBx);
        colHit[f][c] <= 1'b0;   // Captured at this edge
    endtask

    task automatic singleHitReadout(input string label);
        int         c;
        logic [5:0] row;
        logic [5:0] expBcid;
        for (int f = 0; f < NumFlavors; f++) begin
            c   = $urandom % NumCols;
            row = 6'($urandom);
            placeHit(f, c, row, expBcid);
            freeze[f] <= 1'b1;
            readFrame(f, frameOf(c, row, expBcid), $sformatf("%s frame flavor %0d", label, f));
            checkEqual(tokenOut[f], 1'b0, $sformatf("%s token drop flavor %0d", label, f));
            @(posedge ClkBx);
            freeze[f] <= 1'b0;
        end
    endtask

    task automatic columnOrder();
        int                 f;
        int                 first;
        int                 free;
        logic [NumCols-1:0] used;
        logic [5:0]         rows   [NumCols];
        logic [5:0]         stamps [NumCols];
        logic [5:0]         ignored;
        f     = $urandom % NumFlavors;
        used  = '0;
        first = -1;
        free  = -1;
        while ($countones(used) < 3) begin
            used[$urandom % NumCols] = 1'b1;
        end
        // Highest column hit first, so order comes from the encoder
        for (int c = NumCols - 1; c >= 0; c--) begin
            if (used[c]) begin
                rows[c] = 6'($urandom);
                placeHit(f, c, rows[c], stamps[c]);
            end
        end
        for (int c = 0; c < NumCols; c++) begin
            if (used[c] && first < 0) first = c;
            if (!used[c] && free < 0) free = c;
        end
        placeHit(f, first, ~rows[first], ignored);   // Column already full
        freeze[f] <= 1'b1;
        placeHit(f, free, 6'h2A, ignored);           // Frozen, must be dropped
        for (int c = 0; c < NumCols; c++) begin
            if (used[c]) begin
                readFrame(f, frameOf(c, rows[c], stamps[c]),
                          $sformatf("ordered frame column %0d", c));
            end
        end
        checkEqual(tokenOut[f], 1'b0, "no frame left after ordered readout");
        @(posedge ClkBx);
        freeze[f] <= 1'b0;
    endtask

    task automatic hitOrFollow();
        logic [NumFlavors-1:0][NumCols-1:0] pattern;
        @(posedge ClkBx);
        freeze <= '1;   // Keep the columns empty
        for (int i = 0; i < 8; i++) begin
            if (i == 0) begin
                pattern = '0;
            end else begin
                pattern = $urandom & $urandom;
            end
            @(posedge ClkBx);
            colHit <= pattern;
            @(negedge ClkBx);
            for (int f = 0; f < NumFlavors; f++) begin
                checkEqual(hitOr[f], |pattern[f], $sformatf("HitOr flavor %0d", f));
            end
        end
        @(posedge ClkBx);
        colHit <= '0;
        @(posedge ClkBx);
        freeze <= '0;
    endtask

    // MSB first in, old contents come out on ConfOut
    task automatic shiftConf(input logic [11:0] word, input bit load,
                             output logic [11:0] readback);
        for (int i = ConfBits - 1; i >= 0; i--) begin
            @(posedge ClkBx);
            confShift <= 1'b1;
            confIn    <= word[i];
            @(negedge ClkBx);
            readback[i] = confOut;
        end
        @(posedge ClkBx);
        confShift <= 1'b0;
        confLoad  <= load;
        @(posedge ClkBx);
        confLoad <= 1'b0;
    endtask

    task automatic confWrite();
        logic [11:0] readback;
        logic [5:0]  ignored;
        shiftConf(ConfTestWord, 1'b1, readback);
        checkEqual(readback, 12'h000, "shift chain empty after reset");
        placeHit(1, $urandom % NumCols, 6'h15, ignored);
        freeze[1] <= 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge ClkBx);
            checkEqual(tokenOut[1], 1'b0, "token on flavor 1 with readout off");
        end
        @(posedge ClkBx);
        freeze[1] <= 1'b0;
        freeze[2] <= 1'b1;
        @(posedge ClkBx);
        colHit[2] <= 8'($urandom) | 8'h01;
        @(negedge ClkBx);
        checkEqual(hitOr[2], 1'b0, "HitOr on flavor 2 with HitOr off");
        @(posedge ClkBx);
        colHit[2] <= '0;
        @(posedge ClkBx);
        freeze[2] <= 1'b0;
        // No freeze needed, the pattern is always offered
        for (int n = 0; n < 3; n++) begin
            readFrame(3, PatternFrame, $sformatf("test pattern frame %0d", n));
        end
        checkEqual(tokenOut[3], 1'b1, "test pattern token back after frame");
    endtask

    task automatic readbackDefault();
        logic [11:0] readback;
        shiftConf(12'h000, 1'b0, readback);
        checkEqual(readback, ConfTestWord, "configuration readback");
        @(posedge ClkBx);
        defConf <= 1'b1;
        singleHitReadout("default override");
    endtask

    task automatic bcidResetTiming();
        int         delay;
        int         f;
        int         c;
        logic [5:0] row;
        logic [5:0] stamp;
        logic [5:0] expBcid;
        delay = 40 + $urandom % 40;   // Sometimes past the wrap
        f     = $urandom % NumFlavors;
        c     = $urandom % NumCols;
        row   = 6'($urandom);
        @(posedge ClkBx);
        bcidReset <= 1'b1;
        @(posedge ClkBx);
        bcidReset <= 1'b0;   // Counter clears at this edge
        repeat (delay) @(posedge ClkBx);
        placeHit(f, c, row, stamp);
        // Hit driven one edge later, captured on the edge after that
        expBcid = grayOf(6'(delay + 1));
        freeze[f] <= 1'b1;
        readFrame(f, frameOf(c, row, expBcid), "frame after BcidReset");
        @(posedge ClkBx);
        freeze[f] <= 1'b0;
    endtask

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, tests did not complete", WatchdogCycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        void'($urandom(8));
        errorCount = 0;
        checkCount = 0;
        reset_ff   = 1'b1;
        bcidReset  = 1'b0;
        defConf    = 1'b0;
        confShift  = 1'b0;
        confLoad   = 1'b0;
        confIn     = 1'b0;
        colHit     = '0;
        colRow     = '0;
        freeze     = '0;
        readReq    = '0;
        repeat (ResetCycles) @(posedge ClkBx);
        reset_ff <= 1'b0;
        @(negedge ClkBx);
        checkEqual(tokenOut, 4'h0, "TokenOut after reset");
        checkEqual(dataOut, 4'h0, "DataOut after reset");
        checkEqual(hitOr, 4'h0, "HitOr after reset");

        singleHitReadout("single hit");
        columnOrder();
        hitOrFollow();
        confWrite();
        readbackDefault();
        bcidResetTiming();

        repeat (2) @(posedge ClkBx);
        $display("Run complete: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: monopix_digital.f
src/MonopixConfPkg.sv
src/MonopixReadoutPkg.sv
src/ConfReg.sv
src/BcidCounter.sv
src/ColumnBuffer.sv
src/HitSerializer.sv
src/MonopixTop.sv
verif/MonopixTb_asserts.sv
verif/MonopixTb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the monopix_digital testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module MonopixTb -Mdir obj_dir -f monopix_digital.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VMonopixTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "Simulation failed"
exit 1
